//--- source/dmmu_pkg.sv
/*
 Data MMU shared definitions
 Widths, register bus addresses of DTLB way 0, entry bit
 positions and the packed bus structs
*/
package dmmu_pkg;

   localparam int SET_WIDTH  = 6;   // 64 sets
   localparam int PAGE_SHIFT = 13;  // 8 KB pages

   // Register addresses, way 0 only
   localparam logic [15:0] DTLB_MATCH_BASE = 16'h0A00;
   localparam logic [15:0] DTLB_TRANS_BASE = 16'h0A80;
   localparam logic [15:0] DTLB_END        = 16'h0B00;  // First address of way 1

   // Entry bit positions
   localparam int BIT_VALID = 0;  // Match entry
   localparam int BIT_CI    = 1;  // Translate entry from here on
   localparam int BIT_URE   = 6;
   localparam int BIT_UWE   = 7;
   localparam int BIT_SRE   = 8;
   localparam int BIT_SWE   = 9;

   typedef logic [31:0]           operand_t;   // Data word or address
   typedef logic [15:0]           spr_addr_t;
   typedef logic [SET_WIDTH-1:0]  set_idx_t;
   typedef logic [31:PAGE_SHIFT]  vpn_t;       // Page number, bits 31 to 13

   typedef struct packed {
      spr_addr_t addr;
      logic      we;
      logic      stb;   // Held until ack
      operand_t  dat;
   } spr_req_t;

   typedef struct packed {
      operand_t dat;   // Valid in ack cycle
      logic     ack;
   } spr_rsp_t;

   typedef struct packed {
      logic op_load;
      logic op_store;
      logic supervisor;
   } access_t;

   typedef struct packed {
      operand_t phys_addr;
      logic     cache_inhibit;
      logic     tlb_miss;
      logic     pagefault;
   } xlate_t;

endpackage

//--- source/tlb_ram.sv
/*
 TLB RAM
 Single clock, one read and one write port, registered read
 Same address read and write returns the old word
*/
`timescale 1ns/1ns

module tlb_ram (
   input  logic               clk,
   input  dmmu_pkg::set_idx_t raddr_i,
   input  dmmu_pkg::set_idx_t waddr_i,
   input  logic               we_i,
   input  dmmu_pkg::operand_t din_i,
   output dmmu_pkg::operand_t dout_o
);
   import dmmu_pkg::*;

   localparam int DEPTH = 1 << SET_WIDTH;

   operand_t mem [DEPTH];   // Contents undefined until written
   operand_t rd_q;

   always_ff @(posedge clk) begin
      if (we_i) begin
         mem[waddr_i] <= din_i;
      end
      rd_q <= mem[raddr_i];   // Old word on collision, no bypass
   end

   assign dout_o = rd_q;

endmodule

//--- source/dtlb_spr_ctrl.sv
/*
 DTLB register block
 Decodes register bus strobes into the match and translate windows,
 makes the RAM write enables, the ack pulse and the readback select
*/
`timescale 1ns/1ns

module dtlb_spr_ctrl (
   input  logic               clk,
   input  logic               rst,
   input  dmmu_pkg::spr_req_t spr_req_i,
   input  dmmu_pkg::operand_t match_dout_i,
   input  dmmu_pkg::operand_t trans_dout_i,
   output logic               match_sel_o,
   output logic               trans_sel_o,
   output logic               match_we_o,
   output logic               trans_we_o,
   output dmmu_pkg::spr_rsp_t spr_rsp_o
);
   import dmmu_pkg::*;

   logic in_match;    // Address in match window
   logic in_trans;    // Address in translate window
   logic any_sel;
   logic ack_q;       // Set in the strobe's second cycle
   logic ack;
   logic rd_match_q;  // Readback select

   // Window decode
   assign in_match = (spr_req_i.addr >= DTLB_MATCH_BASE) &&
                     (spr_req_i.addr <  DTLB_TRANS_BASE);
   assign in_trans = (spr_req_i.addr >= DTLB_TRANS_BASE) &&
                     (spr_req_i.addr <  DTLB_END);

   assign match_sel_o = spr_req_i.stb & in_match;
   assign trans_sel_o = spr_req_i.stb & in_trans;
   assign any_sel     = match_sel_o | trans_sel_o;

   // Write in both strobe cycles, same data twice
   assign match_we_o = match_sel_o & spr_req_i.we;
   assign trans_we_o = trans_sel_o & spr_req_i.we;

   // Ack state
   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= any_sel & ~ack;   // Clears after one ack, keeps it a pulse
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_match_q <= 1'b0;
      end else begin
         rd_match_q <= match_sel_o;   // RAM word lands one cycle later
      end
   end

   // Only while the strobe is still up
   assign ack = ack_q & any_sel;

   assign spr_rsp_o.ack = ack;
   assign spr_rsp_o.dat = rd_match_q ? match_dout_i : trans_dout_i;

endmodule

//--- source/dtlb_lookup.sv
/*
 DTLB lookup
 Match and translate RAMs with the index mux, then tag compare,
 permission check and physical address in the second stage
*/
`timescale 1ns/1ns

module dtlb_lookup (
   input  logic                clk,
   input  dmmu_pkg::operand_t  virt_addr_i,        // Stage 1, index only
   input  dmmu_pkg::operand_t  virt_addr_match_i,  // Stage 2, full address
   input  dmmu_pkg::access_t   access_i,
   input  dmmu_pkg::spr_addr_t spr_addr_i,
   input  dmmu_pkg::operand_t  spr_dat_i,
   input  logic                match_sel_i,
   input  logic                trans_sel_i,
   input  logic                match_we_i,
   input  logic                trans_we_i,
   output dmmu_pkg::operand_t  match_dout_o,
   output dmmu_pkg::operand_t  trans_dout_o,
   output dmmu_pkg::xlate_t    xlate_o
);
   import dmmu_pkg::*;

   set_idx_t virt_idx;
   set_idx_t match_idx;
   set_idx_t trans_idx;
   operand_t match_dout;
   operand_t trans_dout;
   vpn_t     entry_vpn;
   vpn_t     req_vpn;
   logic     ure, uwe, sre, swe;
   logic     rd_ok;
   logic     wr_ok;

   assign virt_idx = virt_addr_i[PAGE_SHIFT +: SET_WIDTH];   // Bits 18 to 13

   // Bus owns a RAM while it is selected
   assign match_idx = match_sel_i ? spr_addr_i[SET_WIDTH-1:0] : virt_idx;
   assign trans_idx = trans_sel_i ? spr_addr_i[SET_WIDTH-1:0] : virt_idx;

   tlb_ram u_match_ram (
      .clk     (clk),
      .raddr_i (match_idx),
      .waddr_i (match_idx),
      .we_i    (match_we_i),
      .din_i   (spr_dat_i),
      .dout_o  (match_dout)
   );

   tlb_ram u_trans_ram (
      .clk     (clk),
      .raddr_i (trans_idx),
      .waddr_i (trans_idx),
      .we_i    (trans_we_i),
      .din_i   (spr_dat_i),
      .dout_o  (trans_dout)
   );

   assign match_dout_o = match_dout;   // Readback path
   assign trans_dout_o = trans_dout;

   // Tag compare
   assign entry_vpn = match_dout[31:PAGE_SHIFT];
   assign req_vpn   = virt_addr_match_i[31:PAGE_SHIFT];

   // Permission bits of the translate entry
   assign ure = trans_dout[BIT_URE];
   assign uwe = trans_dout[BIT_UWE];
   assign sre = trans_dout[BIT_SRE];
   assign swe = trans_dout[BIT_SWE];

   assign rd_ok = access_i.supervisor ? sre : ure;   // Mode picks the pair
   assign wr_ok = access_i.supervisor ? swe : uwe;

   assign xlate_o.phys_addr     = {trans_dout[31:PAGE_SHIFT],
                                   virt_addr_match_i[PAGE_SHIFT-1:0]};
   assign xlate_o.cache_inhibit = trans_dout[BIT_CI];
   assign xlate_o.tlb_miss      = (entry_vpn != req_vpn) | ~match_dout[BIT_VALID];
   // Independent of the miss
   assign xlate_o.pagefault     = (access_i.op_load & ~rd_ok) |
                                  (access_i.op_store & ~wr_ok);

endmodule

//--- source/dmmu_top.sv
/*
 Data MMU top level
 Register block beside the two-stage DTLB lookup it steers
*/
`timescale 1ns/1ns

module dmmu_top (
   input  logic               clk,
   input  logic               rst,
   input  dmmu_pkg::operand_t virt_addr_i,
   input  dmmu_pkg::operand_t virt_addr_match_i,
   input  dmmu_pkg::access_t  access_i,
   input  dmmu_pkg::spr_req_t spr_req_i,
   output dmmu_pkg::xlate_t   xlate_o,
   output dmmu_pkg::spr_rsp_t spr_rsp_o
);
   import dmmu_pkg::*;

   operand_t match_dout;   // RAM words back to the register block
   operand_t trans_dout;
   logic     match_sel;
   logic     trans_sel;
   logic     match_we;
   logic     trans_we;

   dtlb_spr_ctrl u_spr_ctrl (
      .clk          (clk),
      .rst          (rst),
      .spr_req_i    (spr_req_i),
      .match_dout_i (match_dout),
      .trans_dout_i (trans_dout),
      .match_sel_o  (match_sel),
      .trans_sel_o  (trans_sel),
      .match_we_o   (match_we),
      .trans_we_o   (trans_we),
      .spr_rsp_o    (spr_rsp_o)
   );

   dtlb_lookup u_lookup (
      .clk               (clk),
      .virt_addr_i       (virt_addr_i),
      .virt_addr_match_i (virt_addr_match_i),
      .access_i          (access_i),
      .spr_addr_i        (spr_req_i.addr),
      .spr_dat_i         (spr_req_i.dat),
      .match_sel_i       (match_sel),
      .trans_sel_i       (trans_sel),
      .match_we_i        (match_we),
      .trans_we_i        (trans_we),
      .match_dout_o      (match_dout),
      .trans_dout_o      (trans_dout),
      .xlate_o           (xlate_o)
   );

endmodule

//--- test/dmmu_properties.sv
/*
 DTLB register bus assertions
 Ack pulse shape, strobe dependence, reset and address range
*/
`timescale 1ns/1ns

module dmmu_properties (
   input logic               clk,
   input logic               rst,
   input dmmu_pkg::spr_req_t spr_req_i,
   input dmmu_pkg::spr_rsp_t spr_rsp_i
);
   import dmmu_pkg::*;

   int   fail_count = 0;   // Failed assertions so far
   logic in_range;

   assign in_range = (spr_req_i.addr >= DTLB_MATCH_BASE) && (spr_req_i.addr < DTLB_END);

   ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
      spr_rsp_i.ack |-> spr_req_i.stb)
      else begin
         $error("ack high without stb");
         fail_count++;
      end

   // One-cycle pulse
   ack_single: assert property (@(posedge clk) disable iff (rst)
      spr_rsp_i.ack |=> !spr_rsp_i.ack)
      else begin
         $error("ack high in two consecutive cycles");
         fail_count++;
      end

   ack_low_after_rst: assert property (@(posedge clk) rst |=> !spr_rsp_i.ack)
      else begin
         $error("ack high in the cycle after reset");
         fail_count++;
      end

   ack_in_range: assert property (@(posedge clk) disable iff (rst)
      spr_rsp_i.ack |-> in_range)   // Way 1 and below are not decoded
      else begin
         $error("ack for an address outside the DTLB");
         fail_count++;
      end

endmodule

//--- test/dmmu_checker.sv
/*
 DTLB checker
 Shadow TLB from acknowledged writes, expected translation
 per lookup cycle and readback comparison on ack
*/
`timescale 1ns/1ns

module dmmu_checker (
   input  logic               clk,
   input  logic               rst,
   input  dmmu_pkg::operand_t virt_addr_match_i,
   input  dmmu_pkg::access_t  access_i,
   input  dmmu_pkg::spr_req_t spr_req_i,
   input  dmmu_pkg::spr_rsp_t spr_rsp_i,
   input  dmmu_pkg::xlate_t   xlate_i,
   output int                 check_count_o,
   output int                 error_count_o
);
   import dmmu_pkg::*;

   operand_t shadow_match [64];
   operand_t shadow_trans [64];
   logic     known_match [64];   // Set written at least once
   logic     known_trans [64];

   // Expected lookup result from the entry rules
   function automatic xlate_t expected_xlate(input operand_t va, input access_t acc);
      operand_t m;
      operand_t t;
      logic     rd_ok;
      logic     wr_ok;
      xlate_t   x;
      m = shadow_match[va[18:13]];
      t = shadow_trans[va[18:13]];
      rd_ok = acc.supervisor ? t[BIT_SRE] : t[BIT_URE];
      wr_ok = acc.supervisor ? t[BIT_SWE] : t[BIT_UWE];
      x.phys_addr     = {t[31:13], va[12:0]};   // Page number swapped, offset kept
      x.cache_inhibit = t[BIT_CI];
      x.tlb_miss      = (m[31:13] != va[31:13]) || !m[BIT_VALID];
      x.pagefault     = (acc.op_load && !rd_ok) || (acc.op_store && !wr_ok);
      return x;
   endfunction

   initial begin
      logic     prev_stb;
      int       stb_cycles;   // Length of the current strobe
      set_idx_t idx;
      xlate_t   exp_x;
      operand_t exp_d;
      check_count_o = 0;
      error_count_o = 0;
      prev_stb      = 1'b1;
      stb_cycles    = 0;
      for (int i = 0; i < 64; i++) begin
         known_match[i] = 1'b0;
         known_trans[i] = 1'b0;
      end
      forever begin
         @(negedge clk);   // Inputs settled since posedge + 1
         if (rst) begin
            prev_stb   = 1'b1;
            stb_cycles = 0;
         end else begin
            idx = virt_addr_match_i[18:13];
            // RAMs belong to the lookup only with no strobe now or last cycle
            if (!spr_req_i.stb && !prev_stb && known_match[idx] && known_trans[idx]) begin
               exp_x = expected_xlate(virt_addr_match_i, access_i);
               check_count_o++;
               if (xlate_i !== exp_x) begin
                  $display("CHECK FAILED at %0t ns: xlate_o expected %h, got %h",
                           $time, exp_x, xlate_i);
                  error_count_o++;
               end
            end
            stb_cycles = spr_req_i.stb ? stb_cycles + 1 : 0;
            if (spr_rsp_i.ack) begin
               if (stb_cycles != 2) begin
                  $display("Ack came in strobe cycle %0d instead of the second", stb_cycles);
                  error_count_o++;
               end
               idx = spr_req_i.addr[5:0];
               if (spr_req_i.we && spr_req_i.addr < DTLB_TRANS_BASE) begin
                  shadow_match[idx] = spr_req_i.dat;
                  known_match[idx]  = 1'b1;
               end else if (spr_req_i.we) begin
                  shadow_trans[idx] = spr_req_i.dat;
                  known_trans[idx]  = 1'b1;
               end else begin
                  exp_d = (spr_req_i.addr < DTLB_TRANS_BASE) ? shadow_match[idx]
                                                             : shadow_trans[idx];
                  check_count_o++;
                  if (spr_rsp_i.dat !== exp_d) begin
                     $display("CHECK FAILED at %0t ns: spr_rsp_o.dat expected %h, got %h",
                              $time, exp_d, spr_rsp_i.dat);
                     error_count_o++;
                  end
               end
            end
            prev_stb = spr_req_i.stb;
         end
      end
   end

endmodule

//--- test/dmmu_tb.sv
/*
 Data MMU testbench
 Register bus and two-stage lookup stimulus, watchdog, checker
 beside the DUT and bus assertions bound into the register block
*/
`timescale 1ns/1ns

module dmmu_tb;
   import dmmu_pkg::*;

   localparam int BUS_ACCESSES = 519;   // Strobes over all tests
   localparam int LOOKUPS      = 387;   // Streamed addresses and flushes
   localparam int WATCHDOG_NS  = (3 * BUS_ACCESSES + LOOKUPS) * 10 + 2000;
   localparam spr_addr_t BAD_ADDRS [3] = '{16'h09FF, 16'h0B00, 16'h0B3F};

   logic     clk;
   logic     rst;
   operand_t virt_addr;
   operand_t virt_addr_match;
   access_t  access;
   spr_req_t spr_req;
   spr_rsp_t spr_rsp;
   xlate_t   xlate;
   integer   seed;
   int       tb_errors;
   int       check_count;
   int       check_errors;
   int       last_checks;
   int       last_errors;
   operand_t pend_va;      // Address now in stage 1
   access_t  pend_acc;
   operand_t rd_data;
   logic     acked;
   vpn_t     tags [64];    // Tag written to each set

   dmmu_top u_dut (
      .clk               (clk),
      .rst               (rst),
      .virt_addr_i       (virt_addr),
      .virt_addr_match_i (virt_addr_match),
      .access_i          (access),
      .spr_req_i         (spr_req),
      .xlate_o           (xlate),
      .spr_rsp_o         (spr_rsp)
   );

   dmmu_checker u_checker (
      .clk               (clk),
      .rst               (rst),
      .virt_addr_match_i (virt_addr_match),
      .access_i          (access),
      .spr_req_i         (spr_req),
      .spr_rsp_i         (spr_rsp),
      .xlate_i           (xlate),
      .check_count_o     (check_count),
      .error_count_o     (check_errors)
   );

   bind dtlb_spr_ctrl dmmu_properties u_props (
      .clk       (clk),
      .rst       (rst),
      .spr_req_i (spr_req_i),
      .spr_rsp_i (spr_rsp_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: run still busy after %0d ns", WATCHDOG_NS);
      $display("Test failed");
      $finish;
   end

   function automatic operand_t rand_word();
      rand_word = $random(seed);
   endfunction

   // One strobe, held until ack or for 4 cycles
   task automatic spr_access(input spr_addr_t addr, input logic we, input operand_t dat,
                             output operand_t rdat, output logic got_ack);
      int cycles;
      cycles       = 0;
      got_ack      = 1'b0;
      rdat         = '0;
      spr_req.addr = addr;
      spr_req.we   = we;
      spr_req.dat  = dat;
      spr_req.stb  = 1'b1;
      while (!got_ack && cycles < 4) begin
         @(negedge clk);
         cycles++;
         if (spr_rsp.ack) begin
            got_ack = 1'b1;
            rdat    = spr_rsp.dat;   // Valid in the ack cycle
         end
         @(posedge clk);
         #1;
      end
      spr_req.stb = 1'b0;
      spr_req.we  = 1'b0;
      @(posedge clk);   // Strobe stays low for one cycle
      #1;
   endtask

   task automatic spr_write(input spr_addr_t addr, input operand_t dat);
      spr_access(addr, 1'b1, dat, rd_data, acked);
      if (!acked) begin
         $display("Write to %h got no ack within 4 cycles", addr);
         tb_errors++;
      end
   endtask

   task automatic spr_read(input spr_addr_t addr);
      spr_access(addr, 1'b0, '0, rd_data, acked);
      if (!acked) begin
         $display("Read from %h got no ack within 4 cycles", addr);
         tb_errors++;
      end
   endtask

   // New address into stage 1, last one moves to stage 2
   task automatic lookup(input operand_t va, input access_t acc);
      virt_addr_match = pend_va;
      access          = pend_acc;
      virt_addr       = va;
      pend_va         = va;
      pend_acc        = acc;
      @(posedge clk);
      #1;
   endtask

   task automatic finish_test(input string name);
      $display("%s done: %0d checks, %0d errors", name, check_count - last_checks,
               check_errors + tb_errors - last_errors);
      last_checks = check_count;
      last_errors = check_errors + tb_errors;
   endtask

   initial begin
      int       s;
      int       c;
      int       bit_pos;
      int       fail_total;
      operand_t va;
      seed            = 32'hf5236b76;
      rst             = 1'b1;
      virt_addr       = '0;
      virt_addr_match = '0;
      access          = '0;
      spr_req         = '0;
      pend_va         = '0;
      pend_acc        = '0;
      tb_errors       = 0;
      last_checks     = 0;
      last_errors     = 0;
      repeat (3) @(posedge clk);
      #1;
      rst = 1'b0;

      for (s = 0; s < 64; s++) begin
         spr_write(DTLB_MATCH_BASE + spr_addr_t'(s), rand_word());
         spr_write(DTLB_TRANS_BASE + spr_addr_t'(s), rand_word());
      end
      for (s = 0; s < 64; s++) begin
         spr_read(DTLB_MATCH_BASE + spr_addr_t'(s));
         spr_read(DTLB_TRANS_BASE + spr_addr_t'(s));
      end
      finish_test("Register round trip");

      for (s = 0; s < 64; s++) begin
         va      = rand_word();
         tags[s] = {va[31:19], set_idx_t'(s)};   // Low tag bits are the set
         spr_write(DTLB_MATCH_BASE + spr_addr_t'(s), {tags[s], va[12:1], 1'b1});
         spr_write(DTLB_TRANS_BASE + spr_addr_t'(s), rand_word());
      end
      for (s = 0; s < 64; s++) begin
         va = rand_word();
         lookup({tags[va[18:13]], va[12:0]}, access_t'(va[2:0]));   // Back to back
      end
      lookup(pend_va, pend_acc);
      finish_test("Translation hits");

      for (s = 0; s < 64; s++) begin
         if (s < 32) begin
            spr_write(DTLB_MATCH_BASE + spr_addr_t'(s), {tags[s], 13'h0});   // Valid clear
         end else begin
            bit_pos     = 13 + int'(rand_word() % 32'd19);
            va          = {tags[s], 13'h1};
            va[bit_pos] = ~va[bit_pos];   // Stored tag off by one bit, valid set
            spr_write(DTLB_MATCH_BASE + spr_addr_t'(s), va);
         end
      end
      for (s = 0; s < 64; s++) begin
         va = rand_word();
         lookup({tags[s], va[12:0]}, access_t'(va[2:0]));
      end
      lookup(pend_va, pend_acc);
      finish_test("TLB misses");

      for (s = 0; s < 64; s++) begin
         spr_write(DTLB_TRANS_BASE + spr_addr_t'(s), rand_word());
      end
      for (s = 0; s < 64; s++) begin
         for (c = 0; c < 4; c++) begin
            va = rand_word();
            // Load or store, user or supervisor
            lookup({tags[s], va[12:0]}, access_t'({~c[0], c[0], c[1]}));
         end
      end
      lookup(pend_va, pend_acc);
      finish_test("Permissions");

      for (s = 0; s < 3; s++) begin
         spr_access(BAD_ADDRS[s], 1'b1, rand_word(), rd_data, acked);
         if (acked) begin
            $display("Strobe to %h outside the DTLB was acknowledged", BAD_ADDRS[s]);
            tb_errors++;
         end
      end
      spr_read(16'h0A3F);   // Same low bits as the bad writes
      spr_read(16'h0A00);
      spr_read(16'h0A80);
      spr_read(16'h0ABF);
      finish_test("Out-of-range strobe");

      fail_total = tb_errors + check_errors + u_dut.u_spr_ctrl.u_props.fail_count;
      $display("Summary: %0d checks, %0d check errors, %0d bus errors, %0d assertion failures",
               check_count, check_errors, tb_errors, u_dut.u_spr_ctrl.u_props.fail_count);
      if (fail_total == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

//--- sim.f
source/dmmu_pkg.sv
source/tlb_ram.sv
source/dtlb_spr_ctrl.sv
source/dtlb_lookup.sv
source/dmmu_top.sv
test/dmmu_properties.sv
test/dmmu_checker.sv
test/dmmu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the data MMU testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module dmmu_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vdmmu_tb > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -q "Test failed" "$LOG"; then
   echo "FAIL"
   exit 1
fi
if ! grep -q "Test passed" "$LOG"; then
   echo "FAIL: no result line in $LOG"
   exit 1
fi
echo "PASS"
exit 0
